// ==== hdl/pat_pkg.sv ====
package pat_pkg;

	// ==================================================================
	// word types
	// ==================================================================
	localparam int data_w = 8;          // fixed by the instruction set
	localparam int instr_w = 20;

	typedef logic [data_w-1:0] data_t;
	typedef logic [instr_w-1:0] instr_t;

	// ==================================================================
	// instruction fields
	// ==================================================================
	localparam int cond_hi = 14;        // bits 19:15 and 12 are reserved
	localparam int cond_lo = 13;
	localparam int op_i8_hi = 11;
	localparam int op_i8_lo = 8;
	localparam int imm8_hi = 7;
	localparam int imm8_lo = 0;
	localparam int op_i3_hi = 7;        // overlaps imm8, only seen behind the i8 prefix
	localparam int op_i3_lo = 4;
	localparam int imm3_hi = 2;
	localparam int imm3_lo = 0;
	localparam int op_i0_hi = 3;        // only seen behind both prefixes
	localparam int op_i0_lo = 0;

	// i8 space, 10 and 12 unused
	typedef enum logic [3:0] {
		i8_or = 4'd0,
		i8_and = 4'd1,
		i8_addm = 4'd2,
		i8_subm = 4'd3,
		i8_add = 4'd4,
		i8_sub = 4'd5,
		i8_ldi = 4'd6,
		i8_ldm = 4'd7,
		i8_bf = 4'd8,
		i8_bb = 4'd9,
		i8_stm = 4'd11,
		i8_orm = 4'd13,
		i8_andm = 4'd14,
		i8_prefix = 4'd15              // escape into the i3 space
	} opcode_i8_e;

	typedef enum logic [3:0] {
		i3_shl = 4'd0,
		i3_shlo = 4'd1,
		i3_shr = 4'd2,
		i3_asr = 4'd3,
		i3_in = 4'd5,
		i3_out = 4'd8,
		i3_prefix = 4'd15              // escape into the i0 space
	} opcode_i3_e;

	typedef enum logic [3:0] {
		i0_not = 4'd0,
		i0_test = 4'd2,
		i0_nop = 4'd15
	} opcode_i0_e;

	typedef enum logic [1:0] {
		cond_zero = 2'd0,              // commit on z
		cond_neg = 2'd1,               // commit on n
		cond_always_a = 2'd2,
		cond_always_b = 2'd3
	} cond_e;

	// always-cond, i0 space, opcode 5 does nothing
	localparam instr_t instr_nop = 20'h06ff5;

endpackage

// ==== hdl/pat_alu.sv ====
`timescale 1ns/1ps

module pat_alu (
	input pat_pkg::data_t i_a,
	input pat_pkg::data_t i_b,
	input pat_pkg::opcode_i8_e i_op_i8,
	input pat_pkg::opcode_i3_e i_op_i3,
	input logic i_is_i8,
	input logic i_is_i3,
	output pat_pkg::data_t o_y
);

	logic [2:0] sh;                    // shift count from the i3 immediate
	pat_pkg::data_t ones_fill;         // low bits set by shlo

	assign sh = i_b[2:0];
	assign ones_fill = ~({pat_pkg::data_w{1'b1}} << sh);

	always_comb
	begin
		o_y = i_a;                     // unused opcodes pass the accumulator
		if (i_is_i8)
		begin
			case (i_op_i8)
				pat_pkg::i8_or, pat_pkg::i8_orm: o_y = i_a | i_b;
				pat_pkg::i8_and, pat_pkg::i8_andm: o_y = i_a & i_b;
				pat_pkg::i8_add, pat_pkg::i8_addm: o_y = i_a + i_b;    // wraps at 8 bits
				pat_pkg::i8_sub, pat_pkg::i8_subm: o_y = i_a - i_b;
				default: o_y = i_a;
			endcase
		end
		else if (i_is_i3)
		begin
			case (i_op_i3)
				pat_pkg::i3_shl: o_y = i_a << sh;
				pat_pkg::i3_shlo: o_y = (i_a << sh) | ones_fill;
				pat_pkg::i3_shr: o_y = i_a >> sh;
				pat_pkg::i3_asr: o_y = pat_pkg::data_t'($signed(i_a) >>> sh);  // sign fill
				default: o_y = i_a;
			endcase
		end
		else
		begin
			// i0 space, only not writes the accumulator
			o_y = ~i_a;
		end
	end

endmodule

// ==== hdl/pat_data_mem.sv ====
`timescale 1ns/1ps

module pat_data_mem #(
	parameter int dmem_depth = 32
) (
	input logic clk,
	input logic [$clog2(dmem_depth)-1:0] i_read_adr,
	input logic i_write,
	input logic [$clog2(dmem_depth)-1:0] i_write_adr,
	input pat_pkg::data_t i_write_data,
	output pat_pkg::data_t o_read_data
);

	pat_pkg::data_t mem [0:dmem_depth-1];

	// async read feeds the stage 1 operand mux
	assign o_read_data = mem[i_read_adr];

	// write lands at the commit edge of the stm
	always_ff @(posedge clk)
	begin
		if (i_write)
			mem[i_write_adr] <= i_write_data;
	end

endmodule

// ==== hdl/pat_fetch.sv ====
`timescale 1ns/1ps

module pat_fetch #(
	parameter int imem_adr_width = 10
) (
	input logic clk,
	input logic reset,
	input logic i_imem_write,
	input logic [imem_adr_width-1:0] i_imem_write_adr,
	input pat_pkg::instr_t i_imem_write_data,
	input logic i_jump,
	input logic i_branch_back,
	input pat_pkg::data_t i_branch_offset,
	output logic [imem_adr_width-1:0] o_pc,
	output pat_pkg::instr_t o_instr
);

	localparam int imem_depth = 1 << imem_adr_width;

	pat_pkg::instr_t imem [0:imem_depth-1];    // program store

	logic [imem_adr_width-1:0] offset;
	logic [imem_adr_width-1:0] jump_target;

	// =================================================================
	// branch target
	// =================================================================
	// pc already points one past the branch, so the +1 comes for free
	assign offset = imem_adr_width'(i_branch_offset);    // zero extended
	assign jump_target = i_branch_back ? (o_pc - offset) : (o_pc + offset);  // wraps

	// write port, loaded while the core is held in reset
	always_ff @(posedge clk)
	begin
		if (i_imem_write)
			imem[i_imem_write_adr] <= i_imem_write_data;
	end

	// =================================================================
	// pc and instruction register
	// =================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_pc <= '0;
			o_instr <= pat_pkg::instr_nop;     // first slot is a bubble
		end
		else if (i_jump)
		begin
			o_pc <= jump_target;
			o_instr <= pat_pkg::instr_nop;     // squash the fall-through word
		end
		else
		begin
			o_pc <= o_pc + 1'b1;
			o_instr <= imem[o_pc];             // one word per cycle
		end
	end

	// the squash slot always separates two branches
	a_no_back_to_back_jump : assert property (@(posedge clk) disable iff (reset)
		i_jump |=> !i_jump);

endmodule

// ==== hdl/pat_decode.sv ====
`timescale 1ns/1ps

module pat_decode #(
	parameter int dmem_depth = 32
) (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_t i_instr,
	input pat_pkg::data_t i_read_data,
	output logic o_jump,
	output logic o_branch_back,
	output pat_pkg::data_t o_branch_offset,
	output logic [$clog2(dmem_depth)-1:0] o_dmem_read_adr,
	output pat_pkg::opcode_i8_e o_op_i8,
	output pat_pkg::opcode_i3_e o_op_i3,
	output pat_pkg::opcode_i0_e o_op_i0,
	output logic o_is_i8,
	output logic o_is_i3,
	output logic o_is_i0,
	output pat_pkg::cond_e o_cond,
	output pat_pkg::data_t o_operand,
	output logic [$clog2(dmem_depth)-1:0] o_write_adr
);

	localparam int adr_w = $clog2(dmem_depth);

	pat_pkg::opcode_i8_e op_i8;
	pat_pkg::opcode_i3_e op_i3;
	pat_pkg::opcode_i0_e op_i0;
	pat_pkg::data_t imm8;
	logic [2:0] imm3;
	logic is_i8, is_i3, is_i0;
	logic source_dmem;                 // operand comes from data memory
	pat_pkg::data_t operand;

	// =================================================================
	// stage 1 field split and class decode
	// =================================================================
	assign op_i8 = pat_pkg::opcode_i8_e'(i_instr[pat_pkg::op_i8_hi:pat_pkg::op_i8_lo]);
	assign op_i3 = pat_pkg::opcode_i3_e'(i_instr[pat_pkg::op_i3_hi:pat_pkg::op_i3_lo]);
	assign op_i0 = pat_pkg::opcode_i0_e'(i_instr[pat_pkg::op_i0_hi:pat_pkg::op_i0_lo]);
	assign imm8 = i_instr[pat_pkg::imm8_hi:pat_pkg::imm8_lo];
	assign imm3 = i_instr[pat_pkg::imm3_hi:pat_pkg::imm3_lo];

	assign is_i8 = (op_i8 != pat_pkg::i8_prefix);
	assign is_i3 = !is_i8 && (op_i3 != pat_pkg::i3_prefix);
	assign is_i0 = !is_i8 && !is_i3;   // both prefixes set

	// branches resolve here, fetch squashes the next slot
	assign o_jump = is_i8 && ((op_i8 == pat_pkg::i8_bf) || (op_i8 == pat_pkg::i8_bb));
	assign o_branch_back = is_i8 && (op_i8 == pat_pkg::i8_bb);
	assign o_branch_offset = imm8;

	assign o_dmem_read_adr = imm8[adr_w-1:0];  // modulo dmem_depth

	always_comb
	begin
		source_dmem = 1'b0;
		if (is_i8)
		begin
			case (op_i8)
				pat_pkg::i8_addm, pat_pkg::i8_subm, pat_pkg::i8_ldm,
				pat_pkg::i8_orm, pat_pkg::i8_andm: source_dmem = 1'b1;
				default: source_dmem = 1'b0;
			endcase
		end
	end

	// pre-select the alu b input so stage 2 sees one operand
	assign operand = source_dmem ? i_read_data :
		(is_i8 ? imm8 : {5'b00000, imm3});

	// =================================================================
	// stage 2 registers
	// =================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_is_i8 <= 1'b0;
			o_is_i3 <= 1'b0;
			o_is_i0 <= 1'b0;
		end
		else
		begin
			o_is_i8 <= is_i8;
			o_is_i3 <= is_i3;
			o_is_i0 <= is_i0;
		end
	end

	always_ff @(posedge clk)
	begin
		o_op_i8 <= op_i8;
		o_op_i3 <= op_i3;
		o_op_i0 <= op_i0;
		o_cond <= pat_pkg::cond_e'(i_instr[pat_pkg::cond_hi:pat_pkg::cond_lo]);
		o_operand <= operand;
		o_write_adr <= imm8[adr_w-1:0];   // store address, same field as the read
	end

	// every slot leaving reset carries exactly one instruction class
	a_one_class : assert property (@(posedge clk)
		!reset |=> $onehot({o_is_i8, o_is_i3, o_is_i0}));

endmodule

// ==== hdl/pat_execute.sv ====
`timescale 1ns/1ps

module pat_execute #(
	parameter int dmem_depth = 32
) (
	input logic clk,
	input logic reset,
	input pat_pkg::opcode_i8_e i_op_i8,
	input pat_pkg::opcode_i3_e i_op_i3,
	input pat_pkg::opcode_i0_e i_op_i0,
	input logic i_is_i8,
	input logic i_is_i3,
	input logic i_is_i0,
	input pat_pkg::cond_e i_cond,
	input pat_pkg::data_t i_operand,
	input logic [$clog2(dmem_depth)-1:0] i_write_adr,
	input pat_pkg::data_t i_inputs,
	output logic o_dmem_write,
	output logic [$clog2(dmem_depth)-1:0] o_dmem_write_adr,
	output pat_pkg::data_t o_dmem_write_data,
	output pat_pkg::data_t o_outputs,
	output logic o_out_valid
);

	pat_pkg::data_t acc;               // the accumulator
	pat_pkg::data_t alu_y;
	pat_pkg::data_t acc_next;
	logic z, n;                        // flags written only by test
	logic commit;
	logic acc_load;
	logic is_out, is_test;

	pat_alu i_alu (
		.i_a(acc),
		.i_b(i_operand),
		.i_op_i8(i_op_i8),
		.i_op_i3(i_op_i3),
		.i_is_i8(i_is_i8),
		.i_is_i3(i_is_i3),
		.o_y(alu_y)
	);

	// =================================================================
	// condition and commit decode
	// =================================================================
	always_comb
	begin
		case (i_cond)
			pat_pkg::cond_zero: commit = z;
			pat_pkg::cond_neg: commit = n;
			default: commit = 1'b1;    // both always codes
		endcase
	end

	always_comb
	begin
		acc_load = 1'b0;
		acc_next = alu_y;
		if (i_is_i8)
		begin
			case (i_op_i8)
				pat_pkg::i8_or, pat_pkg::i8_and, pat_pkg::i8_add, pat_pkg::i8_sub,
				pat_pkg::i8_orm, pat_pkg::i8_andm, pat_pkg::i8_addm,
				pat_pkg::i8_subm: acc_load = 1'b1;
				pat_pkg::i8_ldi, pat_pkg::i8_ldm:
				begin
					acc_load = 1'b1;
					acc_next = i_operand;  // imm or mem picked in decode
				end
				default: acc_load = 1'b0;
			endcase
		end
		else if (i_is_i3)
		begin
			case (i_op_i3)
				pat_pkg::i3_shl, pat_pkg::i3_shlo, pat_pkg::i3_shr,
				pat_pkg::i3_asr: acc_load = 1'b1;
				pat_pkg::i3_in:
				begin
					acc_load = 1'b1;
					acc_next = i_inputs;
				end
				default: acc_load = 1'b0;
			endcase
		end
		else if (i_is_i0)
			acc_load = (i_op_i0 == pat_pkg::i0_not);
	end

	assign is_out = i_is_i3 && (i_op_i3 == pat_pkg::i3_out);
	assign is_test = i_is_i0 && (i_op_i0 == pat_pkg::i0_test);

	// store goes straight to memory and lands at this commit edge
	assign o_dmem_write = commit && i_is_i8 && (i_op_i8 == pat_pkg::i8_stm);
	assign o_dmem_write_adr = i_write_adr;
	assign o_dmem_write_data = acc;

	// =================================================================
	// commit registers
	// =================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0;
			z <= 1'b0;
			n <= 1'b0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			o_out_valid <= commit && is_out;   // one-cycle pulse
			if (commit && acc_load)
				acc <= acc_next;
			if (commit && is_test)
			begin
				z <= (acc == '0);
				n <= acc[pat_pkg::data_w-1];
			end
		end
	end

	// output value held until the next out
	always_ff @(posedge clk)
	begin
		if (commit && is_out)
			o_outputs <= acc;
	end

	// a committed store never writes an unknown address or value
	a_store_known : assert property (@(posedge clk) disable iff (reset)
		o_dmem_write |-> !$isunknown({o_dmem_write_adr, o_dmem_write_data}));

endmodule

// ==== hdl/pat_top.sv ====
`timescale 1ns/1ps

module pat_top #(
	parameter int imem_adr_width = 10,
	parameter int dmem_depth = 32      // power of two
) (
	input logic clk,
	input logic reset,
	input logic i_imem_write,
	input logic [imem_adr_width-1:0] i_imem_write_adr,
	input pat_pkg::instr_t i_imem_write_data,
	input pat_pkg::data_t i_inputs,
	output logic [imem_adr_width-1:0] o_pc,
	output pat_pkg::data_t o_outputs,
	output logic o_out_valid
);

	localparam int adr_w = $clog2(dmem_depth);

	// fetch <-> decode
	pat_pkg::instr_t instr;
	logic jump, branch_back;
	pat_pkg::data_t branch_offset;

	// data memory
	logic [adr_w-1:0] dmem_read_adr, dmem_write_adr;
	pat_pkg::data_t read_data, dmem_write_data;
	logic dmem_write;

	// stage 2 slot
	pat_pkg::opcode_i8_e op_i8;
	pat_pkg::opcode_i3_e op_i3;
	pat_pkg::opcode_i0_e op_i0;
	logic is_i8, is_i3, is_i0;
	pat_pkg::cond_e cond;
	pat_pkg::data_t operand;
	logic [adr_w-1:0] write_adr;

	pat_fetch #(.imem_adr_width(imem_adr_width)) i_fetch (
		.clk(clk), .reset(reset),
		.i_imem_write(i_imem_write), .i_imem_write_adr(i_imem_write_adr),
		.i_imem_write_data(i_imem_write_data),
		.i_jump(jump), .i_branch_back(branch_back), .i_branch_offset(branch_offset),
		.o_pc(o_pc), .o_instr(instr)
	);

	pat_decode #(.dmem_depth(dmem_depth)) i_decode (
		.clk(clk), .reset(reset), .i_instr(instr), .i_read_data(read_data),
		.o_jump(jump), .o_branch_back(branch_back), .o_branch_offset(branch_offset),
		.o_dmem_read_adr(dmem_read_adr),
		.o_op_i8(op_i8), .o_op_i3(op_i3), .o_op_i0(op_i0),
		.o_is_i8(is_i8), .o_is_i3(is_i3), .o_is_i0(is_i0), .o_cond(cond),
		.o_operand(operand), .o_write_adr(write_adr)
	);

	pat_data_mem #(.dmem_depth(dmem_depth)) i_data_mem (
		.clk(clk), .i_read_adr(dmem_read_adr),
		.i_write(dmem_write), .i_write_adr(dmem_write_adr),
		.i_write_data(dmem_write_data), .o_read_data(read_data)
	);

	pat_execute #(.dmem_depth(dmem_depth)) i_execute (
		.clk(clk), .reset(reset),
		.i_op_i8(op_i8), .i_op_i3(op_i3), .i_op_i0(op_i0),
		.i_is_i8(is_i8), .i_is_i3(is_i3), .i_is_i0(is_i0), .i_cond(cond),
		.i_operand(operand), .i_write_adr(write_adr), .i_inputs(i_inputs),
		.o_dmem_write(dmem_write), .o_dmem_write_adr(dmem_write_adr),
		.o_dmem_write_data(dmem_write_data),
		.o_outputs(o_outputs), .o_out_valid(o_out_valid)
	);

endmodule

// ==== bench/pat_tb.sv ====
`timescale 1ns/1ps

module pat_tb;

	localparam int imem_adr_width = 10;
	localparam int imem_depth = 1 << imem_adr_width;
	localparam int dmem_depth = 32;
	localparam int num_programs = 16;             // four of each kind
	localparam int max_len = 64;                  // longest program the generator builds
	localparam int cycles_per_prog = 2 * max_len + 60;  // load, run and loop tail

	logic clk = 1'b0;
	logic reset;
	logic i_imem_write;
	logic [imem_adr_width-1:0] i_imem_write_adr;
	pat_pkg::instr_t i_imem_write_data;
	pat_pkg::data_t i_inputs;
	logic [imem_adr_width-1:0] o_pc;
	pat_pkg::data_t o_outputs;
	logic o_out_valid;

	pat_pkg::instr_t prog [$];                    // program under test
	pat_pkg::data_t exp_q [$];                    // outs still expected
	pat_pkg::data_t next_exp;
	logic [31:0] lcg_state = 32'd62596;
	string test_name;
	int pulses;                                   // out pulses seen in this program
	int checks = 0;
	int errors = 0;

	pat_top #(.imem_adr_width(imem_adr_width), .dmem_depth(dmem_depth)) i_dut (
		.clk(clk), .reset(reset),
		.i_imem_write(i_imem_write), .i_imem_write_adr(i_imem_write_adr),
		.i_imem_write_data(i_imem_write_data), .i_inputs(i_inputs),
		.o_pc(o_pc), .o_outputs(o_outputs), .o_out_valid(o_out_valid)
	);

	always #50 clk = ~clk;                        // 100 ns period

	// ====================================================================
	// random numbers and instruction words
	// ====================================================================
	function automatic logic [7:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];                  // middle bits, low ones cycle fast
	endfunction

	function automatic int pick_below(input int range);
		logic [7:0] r;
		r = next_random();
		return r % range;
	endfunction

	function automatic logic [1:0] fixed_cond();
		logic [7:0] r;
		r = next_random();
		return {1'b1, r[0]};                      // one of the two always codes
	endfunction

	function automatic logic [1:0] any_cond();
		logic [7:0] r;
		r = next_random();
		return r[1:0];
	endfunction

	// cls is 8, 3 or 0; reserved bits get junk
	function automatic pat_pkg::instr_t make_word(input int cls, input logic [1:0] cond,
		input logic [3:0] op, input logic [7:0] imm);
		logic [7:0] rsv;
		pat_pkg::instr_t w;
		rsv = next_random();
		if (cls == 8)
			w = {rsv[4:0], cond, rsv[5], op, imm};
		else if (cls == 3)
			w = {rsv[4:0], cond, rsv[5], 4'hf, op, 1'b0, imm[2:0]};
		else
			w = {rsv[4:0], cond, rsv[5], 8'hff, op};
		return w;
	endfunction

	// one random accumulator op, outs are frequent
	task automatic emit_alu(input logic [1:0] cond);
		int r;
		logic [7:0] imm;
		r = pick_below(14);
		imm = next_random();
		case (r)
			0: prog.push_back(make_word(8, cond, pat_pkg::i8_ldi, imm));
			1: prog.push_back(make_word(8, cond, pat_pkg::i8_or, imm));
			2: prog.push_back(make_word(8, cond, pat_pkg::i8_and, imm));
			3: prog.push_back(make_word(8, cond, pat_pkg::i8_add, imm));
			4: prog.push_back(make_word(8, cond, pat_pkg::i8_sub, imm));
			5: prog.push_back(make_word(3, cond, pat_pkg::i3_shl, imm));
			6: prog.push_back(make_word(3, cond, pat_pkg::i3_shlo, imm));
			7: prog.push_back(make_word(3, cond, pat_pkg::i3_shr, imm));
			8: prog.push_back(make_word(3, cond, pat_pkg::i3_asr, imm));
			9: prog.push_back(make_word(0, cond, pat_pkg::i0_not, imm));
			10: prog.push_back(make_word(3, cond, pat_pkg::i3_in, imm));
			11: prog.push_back(make_word(0, cond, pat_pkg::i0_test, imm));
			default: prog.push_back(make_word(3, cond, pat_pkg::i3_out, imm));
		endcase
	endtask

	// ====================================================================
	// program generator, kinds alu / memory / branch / condition
	// ====================================================================
	task automatic build_program(input int kind);
		int n, k, m, adr, t;
		bit stored [0:dmem_depth-1];              // addresses with a known value
		int n_stored;
		logic [7:0] imm;
		logic [3:0] op;
		prog.delete();
		n_stored = 0;
		for (int i = 0; i < dmem_depth; i++)
			stored[i] = 1'b0;
		if (kind == 0)
		begin
			n = 16 + pick_below(16);
			repeat (n)
				emit_alu(fixed_cond());
		end
		else if (kind == 1)
		begin
			n = 12 + pick_below(8);
			repeat (n)
			begin
				k = pick_below(3);
				if (k == 0 || n_stored == 0)
				begin
					imm = next_random();
					prog.push_back(make_word(8, fixed_cond(), pat_pkg::i8_stm, imm));
					prog.push_back(make_word(0, 2'd3, pat_pkg::i0_nop, 8'h00));  // store gap
					if (!stored[imm % dmem_depth])
						n_stored++;
					stored[imm % dmem_depth] = 1'b1;
				end
				else if (k == 1)
					emit_alu(fixed_cond());
				else
				begin
					adr = pick_below(dmem_depth);
					while (!stored[adr])
						adr = (adr + 1) % dmem_depth;
					t = adr + dmem_depth * pick_below(256 / dmem_depth);  // upper bits wrap
					case (pick_below(5))
						0: op = pat_pkg::i8_ldm;
						1: op = pat_pkg::i8_addm;
						2: op = pat_pkg::i8_subm;
						3: op = pat_pkg::i8_orm;
						default: op = pat_pkg::i8_andm;
					endcase
					prog.push_back(make_word(8, fixed_cond(), op, t[7:0]));
					prog.push_back(make_word(3, fixed_cond(), pat_pkg::i3_out, 8'h00));
				end
			end
		end
		else if (kind == 2)
		begin
			repeat (2)
			begin
				repeat (2)
					emit_alu(fixed_cond());
				k = 1 + pick_below(5);            // forward skip, the last skipped is an out
				prog.push_back(make_word(8, any_cond(), pat_pkg::i8_bf, k[7:0]));
				repeat (k - 1)
					emit_alu(fixed_cond());
				prog.push_back(make_word(3, fixed_cond(), pat_pkg::i3_out, 8'h00));
				prog.push_back(make_word(3, fixed_cond(), pat_pkg::i3_out, 8'h00));
				m = 1 + pick_below(4);            // loop body length
				t = m + 1;
				prog.push_back(make_word(8, any_cond(), pat_pkg::i8_bf, 8'd1));  // over the exit
				prog.push_back(make_word(8, any_cond(), pat_pkg::i8_bf, t[7:0]));
				repeat (m - 1)
					emit_alu(fixed_cond());
				prog.push_back(make_word(3, fixed_cond(), pat_pkg::i3_out, 8'h00));
				t = m + 2;
				prog.push_back(make_word(8, any_cond(), pat_pkg::i8_bb, t[7:0]));  // back to exit
				prog.push_back(make_word(3, fixed_cond(), pat_pkg::i3_out, 8'h00));
			end
		end
		else
		begin
			repeat (4)
			begin
				case (pick_below(3))
					0: imm = 8'h00;
					1: imm = next_random() | 8'h80;
					default: imm = (next_random() & 8'h7e) | 8'h01;
				endcase
				prog.push_back(make_word(8, fixed_cond(), pat_pkg::i8_ldi, imm));
				prog.push_back(make_word(0, fixed_cond(), pat_pkg::i0_test, 8'h00));
				repeat (3)
					emit_alu(any_cond());
				prog.push_back(make_word(3, any_cond(), pat_pkg::i3_out, 8'h00));
			end
		end
		prog.push_back(make_word(8, any_cond(), pat_pkg::i8_bb, 8'd1));  // final self-loop
	endtask

	// ====================================================================
	// instruction-set model, fills exp_q and returns the out count
	// ====================================================================
	function automatic int pat_model(input pat_pkg::data_t inputs);
		pat_pkg::data_t acc;
		pat_pkg::data_t mem [0:dmem_depth-1];
		pat_pkg::instr_t w;
		logic [7:0] imm;
		logic z, n, ok, done;
		int pc, adr, steps;
		acc = 8'h00;
		z = 1'b0;
		n = 1'b0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		exp_q.delete();
		for (int i = 0; i < dmem_depth; i++)
			mem[i] = 8'h00;
		while (!done && steps < 4 * max_len)
		begin
			w = prog[pc];
			imm = w[7:0];
			adr = imm % dmem_depth;
			ok = (w[14:13] == 2'd0) ? z : ((w[14:13] == 2'd1) ? n : 1'b1);
			pc = (pc + 1) % imem_depth;
			steps++;
			if (w[11:8] == pat_pkg::i8_bf)          // branches ignore the condition
				pc = (pc + imm) % imem_depth;
			else if (w[11:8] == pat_pkg::i8_bb)
			begin
				if (imm == 8'd1)
					done = 1'b1;                   // self-loop ends the program
				pc = (pc + imem_depth - imm) % imem_depth;
			end
			else if (w[11:8] != 4'hf && ok)
			begin
				case (w[11:8])
					pat_pkg::i8_or: acc = acc | imm;
					pat_pkg::i8_and: acc = acc & imm;
					pat_pkg::i8_add: acc = acc + imm;
					pat_pkg::i8_sub: acc = acc - imm;
					pat_pkg::i8_ldi: acc = imm;
					pat_pkg::i8_ldm: acc = mem[adr];
					pat_pkg::i8_addm: acc = acc + mem[adr];
					pat_pkg::i8_subm: acc = acc - mem[adr];
					pat_pkg::i8_orm: acc = acc | mem[adr];
					pat_pkg::i8_andm: acc = acc & mem[adr];
					pat_pkg::i8_stm: mem[adr] = acc;
					default: ;
				endcase
			end
			else if (w[11:8] == 4'hf && w[7:4] != 4'hf && ok)
			begin
				case (w[7:4])                       // shifts one bit per step
					pat_pkg::i3_shl: repeat (w[2:0]) acc = {acc[6:0], 1'b0};
					pat_pkg::i3_shlo: repeat (w[2:0]) acc = {acc[6:0], 1'b1};
					pat_pkg::i3_shr: repeat (w[2:0]) acc = {1'b0, acc[7:1]};
					pat_pkg::i3_asr: repeat (w[2:0]) acc = {acc[7], acc[7:1]};
					pat_pkg::i3_in: acc = inputs;
					pat_pkg::i3_out: exp_q.push_back(acc);
					default: ;
				endcase
			end
			else if (w[11:4] == 8'hff && ok)
			begin
				if (w[3:0] == pat_pkg::i0_not)
					acc = ~acc;
				else if (w[3:0] == pat_pkg::i0_test)
				begin
					z = (acc == 8'h00);
					n = acc[7];
				end
			end
		end
		return exp_q.size();
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERROR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	// out checker, values are settled at the falling edge
	always @(negedge clk)
	begin
		if (!reset && o_out_valid === 1'b1)
		begin
			pulses++;
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("%s: out pulse with value %0h where none was expected", test_name,
					o_outputs);
			end
			else
			begin
				next_exp = exp_q.pop_front();
				check_value(test_name, {24'h0, next_exp}, {24'h0, o_outputs});
			end
		end
	end

	// ====================================================================
	// per-program sequence
	// ====================================================================
	task automatic run_program(input int p);
		int kind;
		int n_exp;
		int last_adr;
		int cycles;
		pat_pkg::data_t in_value;
		kind = p % 4;
		case (kind)
			0: test_name = $sformatf("alu_%0d", p);
			1: test_name = $sformatf("memory_%0d", p);
			2: test_name = $sformatf("branch_%0d", p);
			default: test_name = $sformatf("condition_%0d", p);
		endcase
		build_program(kind);
		in_value = next_random();
		n_exp = pat_model(in_value);
		last_adr = prog.size() - 1;
		cycles = (prog.size() > 5) ? prog.size() : 5;   // at least 5 reset cycles
		pulses = 0;
		for (int i = 0; i < cycles; i++)
		begin
			@(posedge clk);
			reset <= 1'b1;
			i_inputs <= in_value;
			i_imem_write_adr <= i[imem_adr_width-1:0];
			if (i < prog.size())
			begin
				i_imem_write <= 1'b1;
				i_imem_write_data <= prog[i];
			end
			else
				i_imem_write <= 1'b0;
			@(negedge clk);
			if (i > 0)                            // reset seen by the DUT from here on
			begin
				check_value({test_name, " reset pc"}, 32'h0,
					{{(32 - imem_adr_width){1'b0}}, o_pc});
				check_value({test_name, " reset out_valid"}, 32'h0, {31'h0, o_out_valid});
			end
		end
		@(posedge clk);
		reset <= 1'b0;
		i_imem_write <= 1'b0;
		@(negedge clk);
		check_value({test_name, " pc after reset"}, 32'h0, {{(32 - imem_adr_width){1'b0}}, o_pc});
		check_value({test_name, " out_valid after reset"}, 32'h0, {31'h0, o_out_valid});
		while (o_pc !== last_adr[imem_adr_width-1:0])   // final self-loop reached
			@(negedge clk);
		repeat (20)
			@(negedge clk);
		check_value({test_name, " out count"}, n_exp, pulses);
	endtask

	initial
	begin
		reset = 1'b1;
		i_imem_write = 1'b0;
		i_imem_write_adr = '0;
		i_imem_write_data = '0;
		i_inputs = '0;
		for (int p = 0; p < num_programs; p++)
			run_program(p);
		$display("checks %0d  errors %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog, sized for the longest possible program
	initial
	begin
		#(num_programs * cycles_per_prog * 100);
		$display("timeout: %s did not reach its final loop in time", test_name);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== filelist.f ====
hdl/pat_pkg.sv
hdl/pat_alu.sv
hdl/pat_data_mem.sv
hdl/pat_fetch.sv
hdl/pat_decode.sv
hdl/pat_execute.sv
hdl/pat_top.sv
bench/pat_tb.sv

// ==== Bender.yml ====
package:
  name: pat

sources:
  - hdl/pat_pkg.sv
  - hdl/pat_alu.sv
  - hdl/pat_data_mem.sv
  - hdl/pat_fetch.sv
  - hdl/pat_decode.sv
  - hdl/pat_execute.sv
  - hdl/pat_top.sv
  - target: simulation
    files:
      - bench/pat_tb.sv
